// File: his_top.f
verilog/his_pkg.sv
verilog/his_bank_ram.sv
verilog/his_builder.sv
verilog/his_readout.sv
verilog/his_top.sv
verif/tb_his_top.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Compile and run the histogram testbench with Verilator.
# Exit status is 0 only when the log holds no fail message.

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG=sim.log
TOP=tb_his_top

rm -rf "$BUILD_DIR"
rm -f "$LOG"

verilator --binary --timing --assert \
    --timescale 1ns/1ps \
    -f his_top.f \
    --top-module "$TOP" \
    -Mdir "$BUILD_DIR" \
    -o "$TOP"
if [ $? -ne 0 ]; then
    echo "verilator compile failed"
    exit 1
fi

"./$BUILD_DIR/$TOP" > "$LOG" 2>&1
sim_status=$?
cat "$LOG"
if [ $sim_status -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if grep -q "TEST RESULT: FAIL" "$LOG"; then
    echo "simulation reported failure, see $LOG"
    exit 1
fi

if ! grep -q "TEST RESULT: PASS" "$LOG"; then
    echo "simulation ended without a result line, see $LOG"
    exit 1
fi

exit 0

// File: verif/tb_his_top.sv
module tb_his_top
    import his_pkg::*;
;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIXEL_NUM    = DEF_PIXEL_NUM;
    localparam int DATA_NUM     = DEF_DATA_NUM;
    localparam int ACQ_NUM      = DEF_ACQ_NUM;
    localparam int FRAME_HITS   = DATA_NUM * PIXEL_NUM * ACQ_NUM;
    localparam int RESET_CYCLES = 8;
    localparam int DRAIN_LIMIT  = 200;

    logic     clk;
    logic     res;
    logic     hit_valid;
    hit_t     hit;
    logic     rd_valid;
    rd_word_t rd_word;
    logic     frame_done;
    logic     his_num;

    // bins of the frame being built, one-based
    int       frame_bins[$];
    // expected readout stream, oldest frame first
    rd_word_t exp_q[$];
    int       frame_idx;
    int       done_cnt;
    int       errors;
    int       pass_cnt;
    int       fail_cnt;

    his_top #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) UUT (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit        (hit),
        .rd_valid   (rd_valid),
        .rd_word    (rd_word),
        .frame_done (frame_done),
        .his_num    (his_num)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // hit k goes to pixel (k / DATA_NUM) mod PIXEL_NUM, acquisitions repeat the pixel order
    function automatic int ref_count(input int pix, input int bin);
        int n;
        n = 0;
        foreach (frame_bins[k]) begin
            if (((k / DATA_NUM) % PIXEL_NUM) == pix && frame_bins[k] == bin) begin
                n++;
            end
        end
        return n;
    endfunction

    function automatic int random_bin();
        return int'($urandom_range(NB, 1));
    endfunction

    // expected words of the current frame, pixel-major and bin ascending
    task automatic push_expected();
        rd_word_t w;
        for (int p = 0; p < PIXEL_NUM; p++) begin
            for (int b = 1; b <= NB; b++) begin
                w.his_num = frame_idx[0];
                w.pixel   = PIX_W'(p);
                w.bin     = BIN1_W'(b);
                w.count   = COUNT_W'(ref_count(p, b));
                exp_q.push_back(w);
            end
        end
        frame_idx++;
    endtask

    task automatic fill_directed();
        frame_bins.delete();
        for (int k = 0; k < FRAME_HITS; k++) begin
            frame_bins.push_back(k % NB + 1);
        end
    endtask

    // one pixel gets a single bin, the others random
    task automatic fill_same_bin(input int pix, input int bin);
        frame_bins.delete();
        for (int k = 0; k < FRAME_HITS; k++) begin
            if (((k / DATA_NUM) % PIXEL_NUM) == pix) begin
                frame_bins.push_back(bin);
            end else begin
                frame_bins.push_back(random_bin());
            end
        end
    endtask

    task automatic fill_random();
        frame_bins.delete();
        for (int k = 0; k < FRAME_HITS; k++) begin
            frame_bins.push_back(random_bin());
        end
    endtask

    // leaves hit_valid high after the last hit so frames can run back to back
    task automatic drive_frame(input int max_gap);
        int gap;
        foreach (frame_bins[k]) begin
            @(posedge clk);
            hit_valid <= 1'b1;
            hit.bin   <= BIN1_W'(frame_bins[k]);
            gap = (max_gap > 0) ? int'($urandom_range(max_gap, 0)) : 0;
            repeat (gap) begin
                @(posedge clk);
                hit_valid <= 1'b0;
            end
        end
    endtask

    task automatic go_idle();
        @(posedge clk);
        hit_valid <= 1'b0;
    endtask

    task automatic wait_drained();
        int i;
        i = 0;
        while (exp_q.size() != 0 && i < DRAIN_LIMIT) begin
            @(posedge clk);
            i++;
        end
        if (exp_q.size() != 0) begin
            $display("readout stalled: %0d words still missing after %0d cycles",
                     exp_q.size(), DRAIN_LIMIT);
            errors++;
            exp_q.delete();
        end
        // room for any stray word to show up
        repeat (4) @(posedge clk);
    endtask

    // outputs must stay quiet while res is low
    task automatic apply_reset();
        @(posedge clk);
        res       <= 1'b0;
        hit_valid <= 1'b0;
        exp_q.delete();
        frame_idx = 0;
        repeat (RESET_CYCLES) begin
            @(negedge clk);
            if (rd_valid || frame_done || his_num) begin
                $display("MISMATCH @%0t: output active in reset, rd_valid %b frame_done %b his_num %b",
                         $time, rd_valid, frame_done, his_num);
                errors++;
            end
        end
        @(posedge clk);
        res <= 1'b1;
    endtask

    task automatic end_test(input string name, input int err_start);
        if (errors == err_start) begin
            pass_cnt++;
            $display("test %s: passed", name);
        end else begin
            fail_cnt++;
            $display("test %s: failed with %0d errors", name, errors - err_start);
        end
    endtask

    // compare the readout stream and frame_done against the expected queue
    always @(negedge clk) begin
        rd_word_t exp_w;
        if (!res) begin
            done_cnt = 0;
        end else begin
            if (frame_done) begin
                done_cnt++;
                // his_num already names the next fill bank
                if (his_num != done_cnt[0]) begin
                    $display("MISMATCH @%0t: his_num %b at frame_done %0d, expected %b",
                             $time, his_num, done_cnt, done_cnt[0]);
                    errors++;
                end
            end
            if (rd_valid) begin
                if (exp_q.size() == 0) begin
                    $display("unexpected readout word at %0t with no frame pending", $time);
                    errors++;
                end else begin
                    exp_w = exp_q.pop_front();
                    if (rd_word.pixel != exp_w.pixel || rd_word.bin != exp_w.bin) begin
                        $display("MISMATCH @%0t: order, got pixel %0d bin %0d, expected %0d %0d",
                                 $time, rd_word.pixel, rd_word.bin, exp_w.pixel, exp_w.bin);
                        errors++;
                    end
                    if (rd_word.count != exp_w.count) begin
                        $display("MISMATCH @%0t: pixel %0d bin %0d count %0d, expected %0d",
                                 $time, exp_w.pixel, exp_w.bin, rd_word.count, exp_w.count);
                        errors++;
                    end
                    if (rd_word.his_num != exp_w.his_num) begin
                        $display("MISMATCH @%0t: word his_num %b, expected %b",
                                 $time, rd_word.his_num, exp_w.his_num);
                        errors++;
                    end
                end
            end
        end
    end

    initial begin
        int err_start;
        res       = 1'b0;
        hit_valid = 1'b0;
        hit       = '0;
        errors    = 0;
        pass_cnt  = 0;
        fail_cnt  = 0;
        frame_idx = 0;
        done_cnt  = 0;
        void'($urandom(57));
        apply_reset();

        // every bin once per pixel and acquisition
        err_start = errors;
        fill_directed();
        push_expected();
        drive_frame(0);
        go_idle();
        wait_drained();
        end_test("directed_frame", err_start);

        // back-to-back same address goes through the bypass
        err_start = errors;
        fill_same_bin(2, 5);
        push_expected();
        drive_frame(0);
        go_idle();
        wait_drained();
        end_test("same_bin_burst", err_start);

        err_start = errors;
        for (int f = 0; f < 3; f++) begin
            fill_random();
            push_expected();
            drive_frame(3);
        end
        go_idle();
        wait_drained();
        end_test("random_gaps", err_start);

        // next frame fills while the last one is read and cleared
        err_start = errors;
        for (int f = 0; f < 4; f++) begin
            fill_random();
            push_expected();
            drive_frame(0);
        end
        go_idle();
        wait_drained();
        end_test("back_to_back", err_start);

        // partial frame, then reset drops it
        err_start = errors;
        fill_random();
        frame_bins = frame_bins[0:FRAME_HITS/2 - 3];
        drive_frame(1);
        apply_reset();
        @(negedge clk);
        if (his_num != 1'b0) begin
            $display("MISMATCH @%0t: his_num %b after reset, expected 0", $time, his_num);
            errors++;
        end
        // second frame lands in the bank the dropped hits went to
        for (int f = 0; f < 2; f++) begin
            fill_random();
            push_expected();
            drive_frame(0);
        end
        go_idle();
        wait_drained();
        end_test("reset_mid_frame", err_start);

        $display("tests passed: %0d, tests failed: %0d, errors: %0d", pass_cnt, fail_cnt, errors);
        if (fail_cnt == 0 && errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: verilog/his_top.sv
module his_top
    import his_pkg::*;
#(
    parameter int PIXEL_NUM = DEF_PIXEL_NUM,
    parameter int DATA_NUM  = DEF_DATA_NUM,
    parameter int ACQ_NUM   = DEF_ACQ_NUM
) (
    input  logic     clk,
    input  logic     res,
    input  logic     hit_valid,
    input  hit_t     hit,
    output logic     rd_valid,
    output rd_word_t rd_word,
    output logic     frame_done,
    output logic     his_num
);

    // builder side of the memory
    logic [ADDR_W-1:0]  rd_addr_a;
    ram_wr_t            wr_a;
    logic               wr_en_a;
    logic [COUNT_W-1:0] rd_data_a;
    // readout side
    logic [ADDR_W-1:0]  rd_addr_b;
    logic [ADDR_W-1:0]  clr_b;
    logic               clr_en_b;
    logic [COUNT_W-1:0] rd_data_b;

    his_builder #(
        .PIXEL_NUM (PIXEL_NUM),
        .DATA_NUM  (DATA_NUM),
        .ACQ_NUM   (ACQ_NUM)
    ) u_builder (
        .clk        (clk),
        .res        (res),
        .hit_valid  (hit_valid),
        .hit        (hit),
        .rd_data    (rd_data_a),
        .rd_addr    (rd_addr_a),
        .wr         (wr_a),
        .wr_en      (wr_en_a),
        .his_num    (his_num),
        .frame_done (frame_done)
    );

    his_bank_ram #(
        .PIXEL_NUM (PIXEL_NUM)
    ) u_ram (
        .clk       (clk),
        .res       (res),
        .rd_addr_a (rd_addr_a),
        .wr_a      (wr_a),
        .wr_en_a   (wr_en_a),
        .rd_data_a (rd_data_a),
        .rd_addr_b (rd_addr_b),
        .clr_b     (clr_b),
        .clr_en_b  (clr_en_b),
        .rd_data_b (rd_data_b)
    );

    his_readout #(
        .PIXEL_NUM (PIXEL_NUM)
    ) u_readout (
        .clk        (clk),
        .res        (res),
        .frame_done (frame_done),
        .his_num    (his_num),
        .rd_data    (rd_data_b),
        .rd_addr    (rd_addr_b),
        .clr        (clr_b),
        .clr_en     (clr_en_b),
        .rd_valid   (rd_valid),
        .rd_word    (rd_word)
    );

endmodule

// File: verilog/his_readout.sv
module his_readout
    import his_pkg::*;
#(
    parameter int PIXEL_NUM = DEF_PIXEL_NUM
) (
    input  logic               clk,
    input  logic               res,
    input  logic               frame_done,
    input  logic               his_num,
    input  logic [COUNT_W-1:0] rd_data,
    output logic [ADDR_W-1:0]  rd_addr,
    output logic [ADDR_W-1:0]  clr,
    output logic               clr_en,
    output logic               rd_valid,
    output rd_word_t           rd_word
);

    // sweep state
    logic             busy;
    logic             bank;
    logic [PIX_W-1:0] pix;
    logic [BIN_W-1:0] bin;

    // address presented this cycle
    logic             start;
    logic             rd_go;
    logic             rd_bank;
    logic [PIX_W-1:0] rd_pix;
    logic [BIN_W-1:0] rd_bin;
    logic             last;

    // word in flight, read issued on the previous edge
    logic              v1;
    logic [ADDR_W-1:0] a1;

    assign start = frame_done && !busy;
    assign rd_go = start || busy;

    // first address goes out on the frame_done edge itself
    assign rd_bank = busy ? bank : ~his_num;
    assign rd_pix  = busy ? pix : '0;
    assign rd_bin  = busy ? bin : '0;
    assign rd_addr = {rd_bank, rd_pix, rd_bin};

    assign last = (rd_pix == PIX_W'(PIXEL_NUM - 1)) && (rd_bin == BIN_W'(NB - 1));

    // pixel-major, bin ascending
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            busy <= 1'b0;
            bank <= 1'b0;
            pix  <= '0;
            bin  <= '0;
        end else if (rd_go) begin
            bank <= rd_bank;
            busy <= !last;
            if (rd_bin == BIN_W'(NB - 1)) begin
                bin <= '0;
                pix <= rd_pix + 1'b1;
            end else begin
                bin <= rd_bin + 1'b1;
                pix <= rd_pix;
            end
        end
    end

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            v1       <= 1'b0;
            rd_valid <= 1'b0;
        end else begin
            v1       <= rd_go;
            rd_valid <= v1;
        end
    end

    // output word, count comes straight from the memory register
    always_ff @(posedge clk) begin
        a1              <= rd_addr;
        rd_word.his_num <= a1[ADDR_W-1];
        rd_word.pixel   <= a1[BIN_W +: PIX_W];
        rd_word.bin     <= {1'b0, a1[BIN_W-1:0]} + BIN1_W'(1);
        rd_word.count   <= rd_data;
    end

    // clear trails the read by one cycle
    assign clr    = a1;
    assign clr_en = v1;

    // next frame must not end before this sweep is out
    a_no_overlap: assert property (@(posedge clk) disable iff (!res)
        frame_done |-> !busy);

endmodule

// File: verilog/his_builder.sv
module his_builder
    import his_pkg::*;
#(
    parameter int PIXEL_NUM = DEF_PIXEL_NUM,
    parameter int DATA_NUM  = DEF_DATA_NUM,
    parameter int ACQ_NUM   = DEF_ACQ_NUM
) (
    input  logic               clk,
    input  logic               res,
    input  logic               hit_valid,
    input  hit_t               hit,
    input  logic [COUNT_W-1:0] rd_data,
    output logic [ADDR_W-1:0]  rd_addr,
    output ram_wr_t            wr,
    output logic               wr_en,
    output logic               his_num,
    output logic               frame_done
);

    localparam int IN_W  = (DATA_NUM > 1) ? $clog2(DATA_NUM) : 1;
    localparam int ACQ_W = (ACQ_NUM > 1) ? $clog2(ACQ_NUM) : 1;

    // hit sequencing
    logic [IN_W-1:0]  in_cnt;
    logic [PIX_W-1:0] pix_cnt;
    logic [ACQ_W-1:0] acq_cnt;
    logic             in_wrap;
    logic             pix_wrap;
    logic             acq_wrap;
    logic             frame_end;
    // fill bank, flips right after the last hit of a frame
    logic             bank;
    logic [BIN_W-1:0] bin_idx;

    // increment stage
    logic              v1;
    logic [ADDR_W-1:0] a1;
    // last write, for the same-address bypass
    logic               last_v;
    logic [ADDR_W-1:0]  last_addr;
    logic [COUNT_W-1:0] last_data;
    logic [COUNT_W-1:0] base;

    // frame end delay line
    logic end1;
    logic end2;

    assign in_wrap   = in_cnt == IN_W'(DATA_NUM - 1);
    assign pix_wrap  = pix_cnt == PIX_W'(PIXEL_NUM - 1);
    assign acq_wrap  = acq_cnt == ACQ_W'(ACQ_NUM - 1);
    assign frame_end = hit_valid && in_wrap && pix_wrap && acq_wrap;

    // bins arrive one-based
    assign bin_idx = BIN_W'(hit.bin - BIN1_W'(1));

    // read goes out on the edge the hit is taken
    assign rd_addr = {bank, pix_cnt, bin_idx};

    // input count wraps into pixel count, pixel count into acquisition count
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            in_cnt  <= '0;
            pix_cnt <= '0;
            acq_cnt <= '0;
            bank    <= 1'b0;
        end else if (hit_valid) begin
            if (!in_wrap) begin
                in_cnt <= in_cnt + 1'b1;
            end else begin
                in_cnt <= '0;
                if (!pix_wrap) begin
                    pix_cnt <= pix_cnt + 1'b1;
                end else begin
                    pix_cnt <= '0;
                    if (!acq_wrap) begin
                        acq_cnt <= acq_cnt + 1'b1;
                    end else begin
                        // frame complete, next hit fills the other bank
                        acq_cnt <= '0;
                        bank    <= ~bank;
                    end
                end
            end
        end
    end

    // control of the increment pipe and frame end
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            v1         <= 1'b0;
            last_v     <= 1'b0;
            end1       <= 1'b0;
            end2       <= 1'b0;
            his_num    <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            v1     <= hit_valid;
            last_v <= v1;
            end1   <= frame_end;
            end2   <= end1;
            // his_num follows the fill bank one cycle late
            his_num    <= bank;
            // old bank fully written by now
            frame_done <= end2;
        end
    end

    // payload of the pipe
    always_ff @(posedge clk) begin
        a1        <= rd_addr;
        last_addr <= a1;
        last_data <= wr.data;
    end

    // read from the previous edge misses the write on that same edge
    assign base = (last_v && (last_addr == a1)) ? last_data : rd_data;

    assign wr.addr = a1;
    assign wr.data = base + 1'b1;
    assign wr_en   = v1;

    // bin 0 is outside the one-based range
    a_bin_legal: assert property (@(posedge clk) disable iff (!res)
        hit_valid |-> (hit.bin != '0 && int'(hit.bin) <= NB));

    // finished bank takes no more writes once frame_done is out
    a_frame_closed: assert property (@(posedge clk) disable iff (!res)
        (frame_done && wr_en) |-> (wr.addr[ADDR_W-1] == his_num));

endmodule

// File: verilog/his_bank_ram.sv
module his_bank_ram
    import his_pkg::*;
#(
    parameter int PIXEL_NUM = DEF_PIXEL_NUM
) (
    input  logic               clk,
    input  logic               res,
    // builder port
    input  logic [ADDR_W-1:0]  rd_addr_a,
    input  ram_wr_t            wr_a,
    input  logic               wr_en_a,
    output logic [COUNT_W-1:0] rd_data_a,
    // readout port, writes zero only
    input  logic [ADDR_W-1:0]  rd_addr_b,
    input  logic [ADDR_W-1:0]  clr_b,
    input  logic               clr_en_b,
    output logic [COUNT_W-1:0] rd_data_b
);

    localparam int DEPTH = 2 ** ADDR_W;

    // both banks of counters
    logic [COUNT_W-1:0] mem [DEPTH];

    // array clears on reset so a fresh frame starts from zero
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            for (int i = 0; i < DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else begin
            if (wr_en_a) begin
                mem[wr_a.addr] <= wr_a.data;
            end
            // clear of the finished bank
            if (clr_en_b) begin
                mem[clr_b] <= '0;
            end
        end
    end

    // registered reads, old data on a same-edge write
    always_ff @(posedge clk) begin
        rd_data_a <= mem[rd_addr_a];
        rd_data_b <= mem[rd_addr_b];
    end

    // builder and readout must always work in different banks
    a_bank_split: assert property (@(posedge clk) disable iff (!res)
        (wr_en_a && clr_en_b) |-> (wr_a.addr[ADDR_W-1] != clr_b[ADDR_W-1]));

    // pixel field stays inside the configured array
    a_pix_range_a: assert property (@(posedge clk) disable iff (!res)
        wr_en_a |-> (int'(wr_a.addr[BIN_W +: PIX_W]) < PIXEL_NUM));

    a_pix_range_b: assert property (@(posedge clk) disable iff (!res)
        clr_en_b |-> (int'(clr_b[BIN_W +: PIX_W]) < PIXEL_NUM));

endmodule

// File: verilog/his_pkg.sv
package his_pkg;

    // histogram geometry
    localparam int BIN_W   = 3;
    localparam int NB      = 8;
    localparam int PIX_W   = 2;
    localparam int COUNT_W = 8;

    // one-based bin index 1..NB needs one more bit than the stored index
    localparam int BIN1_W  = BIN_W + 1;

    // bank bit on top, then pixel, then bin minus one
    localparam int ADDR_W  = 1 + PIX_W + BIN_W;

    // default acquisition geometry, top level overrides these
    localparam int DEF_PIXEL_NUM = 4;
    localparam int DEF_DATA_NUM  = 8;
    localparam int DEF_ACQ_NUM   = 2;

    // one binned hit from upstream
    typedef struct packed {
        logic [BIN1_W-1:0] bin;
    } hit_t;

    // builder write into the counter memory
    typedef struct packed {
        logic [ADDR_W-1:0]  addr;
        logic [COUNT_W-1:0] data;
    } ram_wr_t;

    // one word of the readout stream
    typedef struct packed {
        logic               his_num;
        logic [PIX_W-1:0]   pixel;
        logic [BIN1_W-1:0]  bin;
        logic [COUNT_W-1:0] count;
    } rd_word_t;

endpackage
